// File: dat_phys.f
logic/dat_phys_pkg.sv
logic/par_to_ser.sv
logic/ser_to_par.sv
logic/dat_pad.sv
logic/dat_phys_controller.sv
logic/dat_phys.sv
sim/dat_phys_properties.sv
sim/dat_phys_tb.sv

// File: logic/dat_pad.sv
`timescale 1ns/100ps

module dat_pad (
	input  logic sd_clock,
	input  logic arst_n,
	input  logic output_input,
	input  logic enable,
	input  logic data_in,
	output logic data_out,
	inout  wire  io_port
);

	logic drive_q;
	logic out_q;

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			drive_q <= 1'b0;
		end else begin
			drive_q <= output_input && enable;
		end
	end

	// pin data and input sample both lag one cycle
	always_ff @(posedge sd_clock) begin
		out_q <= data_in;
		data_out <= io_port;
	end

	assign io_port = drive_q ? out_q : 1'bz;

endmodule

// File: logic/dat_phys.sv
`timescale 1ns/100ps

module dat_phys
	import dat_phys_pkg::*;
#(
	parameter int frame_width = data_frame_width,
	parameter int timeout_width = 64
) (
	input  logic sd_clock,
	input  logic arst_n,
	// host
	input  logic strobe_in,
	input  logic ack_in,
	input  logic idle_in,
	input  logic [timeout_width-1:0] timeout_reg,
	input  logic [block_width-1:0] blocks,
	input  logic write_read,
	input  logic multiple,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic data_error,
	// FIFOs
	output logic read_enable,
	output logic write_enable,
	output logic [data_width-1:0] data_to_fifo,
	input  logic status,
	input  logic [data_width-1:0] dat_from_fifo,
	inout  wire  dat_pin
);

	logic [frame_width-1:0] tx_frame;
	rx_frame_t rx_frame;
	logic [frame_count_width-1:0] framesize;
	logic load_send;
	logic enable_tx;
	logic enable_rx;
	logic shift_reset;
	logic tx_complete;
	logic rx_complete;
	logic tx_serial;
	logic rx_serial;
	logic pad_output;
	logic pad_enable;

	// start, data, fill in place of crc, end
	assign tx_frame = {1'b0, dat_from_fifo, {fill_width{1'b1}}, 1'b1};

	dat_phys_controller #(
		.timeout_width(timeout_width)
	) i_controller (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.timeout_reg(timeout_reg),
		.blocks(blocks),
		.write_read(write_read),
		.multiple(multiple),
		.status(status),
		.tx_complete(tx_complete),
		.rx_complete(rx_complete),
		.rx_frame(rx_frame),
		.serial_ready(serial_ready),
		.complete(complete),
		.ack_out(ack_out),
		.data_timeout(data_timeout),
		.data_error(data_error),
		.read_enable(read_enable),
		.write_enable(write_enable),
		.data_to_fifo(data_to_fifo),
		.load_send(load_send),
		.enable_tx(enable_tx),
		.enable_rx(enable_rx),
		.shift_reset(shift_reset),
		.framesize(framesize),
		.pad_output(pad_output),
		.pad_enable(pad_enable)
	);

	par_to_ser #(
		.frame_width(frame_width)
	) i_par_to_ser (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.enable(enable_tx),
		.load_send(load_send),
		.parallel(tx_frame),
		.serial(tx_serial),
		.complete(tx_complete)
	);

	ser_to_par #(
		.frame_width(frame_width)
	) i_ser_to_par (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.enable(enable_rx),
		.reset_shift(shift_reset),
		.framesize(framesize),
		.serial(rx_serial),
		.parallel(rx_frame),
		.complete(rx_complete)
	);

	dat_pad i_dat_pad (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.output_input(pad_output),
		.enable(pad_enable),
		.data_in(tx_serial),
		.data_out(rx_serial),
		.io_port(dat_pin)
	);

endmodule

// File: logic/dat_phys_controller.sv
`timescale 1ns/100ps

module dat_phys_controller
	import dat_phys_pkg::*;
#(
	parameter int timeout_width = 64
) (
	input  logic sd_clock,
	input  logic arst_n,
	input  logic strobe_in,
	input  logic ack_in,
	input  logic idle_in,
	input  logic [timeout_width-1:0] timeout_reg,
	input  logic [block_width-1:0] blocks,
	input  logic write_read,
	input  logic multiple,
	input  logic status,
	input  logic tx_complete,
	input  logic rx_complete,
	input  rx_frame_t rx_frame,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic data_error,
	output logic read_enable,
	output logic write_enable,
	output logic [data_width-1:0] data_to_fifo,
	output logic load_send,
	output logic enable_tx,
	output logic enable_rx,
	output logic shift_reset,
	output logic [frame_count_width-1:0] framesize,
	output logic pad_output,
	output logic pad_enable
);

	localparam logic [3:0] st_idle = 4'd0;
	localparam logic [3:0] st_fetch = 4'd1;
	localparam logic [3:0] st_load = 4'd2;
	localparam logic [3:0] st_send = 4'd3;
	localparam logic [3:0] st_turnaround = 4'd4;
	localparam logic [3:0] st_wait_token = 4'd5;
	localparam logic [3:0] st_wait_data = 4'd6;
	localparam logic [3:0] st_push = 4'd7;
	localparam logic [3:0] st_done = 4'd8;
	localparam logic [3:0] st_ack = 4'd9;

	logic [3:0] state;
	logic [3:0] state_next;
	logic [block_width-1:0] blocks_left;
	logic [timeout_width-1:0] wait_count;
	logic write_q;
	logic waiting;
	logic last_block;
	logic token_ok;
	logic timed_out;
	logic start;
	logic next_block;

	assign waiting = (state == st_wait_token) || (state == st_wait_data);
	assign last_block = (blocks_left <= 1);
	assign token_ok = (rx_frame.token_view.token == token_accepted);
	assign timed_out = waiting && (wait_count == timeout_reg);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (strobe_in) begin
					state_next = write_read ? st_fetch : st_wait_data;
				end
			end
			// hold here while the transmit FIFO is empty
			st_fetch: begin
				if (status) begin
					state_next = st_load;
				end
			end
			st_load: state_next = st_send;
			st_send: begin
				if (tx_complete) begin
					state_next = st_turnaround;
				end
			end
			st_turnaround: state_next = st_wait_token;
			st_wait_token: begin
				if (rx_complete) begin
					state_next = (token_ok && !last_block) ? st_fetch : st_done;
				end else if (timed_out) begin
					state_next = st_done;
				end
			end
			st_wait_data: begin
				if (rx_complete) begin
					state_next = st_push;
				end else if (timed_out) begin
					state_next = st_done;
				end
			end
			st_push: state_next = last_block ? st_done : st_wait_data;
			st_done: begin
				if (ack_in) begin
					state_next = st_ack;
				end
			end
			st_ack: state_next = st_idle;
			default: state_next = st_idle;
		endcase
		// abort wins over everything
		if (idle_in) begin
			state_next = st_idle;
		end
	end

	assign start = (state == st_idle) && (state_next != st_idle);
	assign next_block = ((state == st_wait_token) && (state_next == st_fetch)) ||
		((state == st_push) && (state_next == st_wait_data));

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			blocks_left <= '0;
			write_q <= 1'b0;
			data_timeout <= 1'b0;
			data_error <= 1'b0;
		end else begin
			state <= state_next;
			if (start) begin
				blocks_left <= multiple ? blocks : block_width'(1);
				write_q <= write_read;
				data_timeout <= 1'b0;
				data_error <= 1'b0;
			end else if (next_block) begin
				blocks_left <= blocks_left - 1'b1;
			end
			if (state_next == st_done) begin
				if (state == st_wait_token && rx_complete && !token_ok) begin
					data_error <= 1'b1;
				end
				if (waiting && !rx_complete) begin
					data_timeout <= 1'b1;
				end
			end
		end
	end

	// counts the whole wait for a token or a frame
	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			wait_count <= '0;
		end else if (waiting) begin
			wait_count <= wait_count + 1'b1;
		end else begin
			wait_count <= '0;
		end
	end

	assign serial_ready = (state == st_idle);
	assign complete = (state == st_done);
	assign ack_out = (state == st_ack);
	assign read_enable = (state == st_fetch) && status;
	assign load_send = (state == st_load);
	assign enable_tx = (state == st_send);
	assign enable_rx = waiting;
	assign write_enable = (state == st_push);
	assign data_to_fifo = rx_frame.data_view.data;

	// receiver cleared before every capture
	assign shift_reset = (state == st_idle) || (state == st_turnaround) || (state == st_push);

	assign framesize = (state == st_wait_token) ? frame_count_width'(token_width) :
		frame_count_width'(data_frame_width);

	assign pad_output = write_q;
	assign pad_enable = (state == st_send);

endmodule

// File: logic/dat_phys_pkg.sv
package dat_phys_pkg;

	// frame geometry
	localparam int data_frame_width = 50;
	localparam int data_width = 32;
	localparam int fill_width = 16;
	localparam int frame_count_width = 8;
	localparam int block_width = 4;

	// status token from the card after a written block
	localparam int token_width = 3;
	localparam logic [token_width-1:0] token_accepted = 3'b010;

	typedef struct packed {
		logic start_bit;
		logic [data_width-1:0] data;
		logic [fill_width-1:0] fill;
		logic end_bit;
	} data_view_t;

	// token is shifted in from the low end
	typedef struct packed {
		logic [data_frame_width-token_width-1:0] unused;
		logic [token_width-1:0] token;
	} token_view_t;

	typedef union packed {
		data_view_t data_view;
		token_view_t token_view;
	} rx_frame_t;

endpackage

// File: logic/par_to_ser.sv
`timescale 1ns/100ps

module par_to_ser
	import dat_phys_pkg::*;
#(
	parameter int frame_width = data_frame_width
) (
	input  logic sd_clock,
	input  logic arst_n,
	input  logic enable,
	input  logic load_send,
	input  logic [frame_width-1:0] parallel,
	output logic serial,
	output logic complete
);

	logic [frame_width-1:0] shift_q;
	logic [frame_count_width-1:0] count_q;

	// msb first
	assign serial = shift_q[frame_width-1];

	// flags the cycle that carries the last bit
	assign complete = enable && (count_q == frame_count_width'(frame_width - 1));

	always_ff @(posedge sd_clock) begin
		if (load_send) begin
			shift_q <= parallel;
		end else if (enable) begin
			// line idles high behind the frame
			shift_q <= {shift_q[frame_width-2:0], 1'b1};
		end
	end

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (load_send) begin
			count_q <= '0;
		end else if (enable) begin
			count_q <= count_q + 1'b1;
		end
	end

endmodule

// File: logic/ser_to_par.sv
`timescale 1ns/100ps

module ser_to_par
	import dat_phys_pkg::*;
#(
	parameter int frame_width = data_frame_width
) (
	input  logic sd_clock,
	input  logic arst_n,
	input  logic enable,
	input  logic reset_shift,
	input  logic [frame_count_width-1:0] framesize,
	input  logic serial,
	output rx_frame_t parallel,
	output logic complete
);

	logic [frame_width-1:0] shift_q;
	logic [frame_count_width-1:0] count_q;
	logic [frame_count_width-1:0] count_next;
	logic hunting;
	logic shift_now;

	// count of zero means no start bit yet
	assign hunting = (count_q == '0);
	assign count_next = count_q + 1'b1;

	// stops by itself once framesize bits are in
	assign shift_now = enable && (hunting ? (serial == 1'b0) : (count_q < framesize));

	assign parallel = shift_q;

	always_ff @(posedge sd_clock) begin
		if (reset_shift) begin
			shift_q <= '0;
		end else if (shift_now) begin
			shift_q <= {shift_q[frame_width-2:0], serial};
		end
	end

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
			complete <= 1'b0;
		end else if (reset_shift) begin
			count_q <= '0;
			complete <= 1'b0;
		end else begin
			complete <= shift_now && (count_next == framesize);
			if (shift_now) begin
				count_q <= count_next;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dat_phys testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f dat_phys.f --top-module dat_phys_tb \
	-o dat_phys_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dat_phys_sim > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && { echo "simulation passed"; exit 0; } ||
	{ echo "simulation ended without a result"; exit 1; }

// File: sim/dat_phys_properties.sv
`timescale 1ns/100ps

module dat_phys_properties (
	input logic sd_clock,
	input logic arst_n,
	input logic read_enable,
	input logic write_enable,
	input logic ack_out,
	input logic complete,
	input logic ack_in,
	input logic idle_in,
	input logic enable_rx,
	input logic pad_enable
);

	// transmit and receive FIFOs never strobed in the same cycle
	fifo_strobes_apart: assert property (@(posedge sd_clock) disable iff (!arst_n)
		!(read_enable && write_enable))
		else $error("read_enable and write_enable are high in the same cycle");

	ack_single_cycle: assert property (@(posedge sd_clock) disable iff (!arst_n)
		ack_out |=> !ack_out)
		else $error("ack_out is high for more than one cycle");

	// an abort is the only other way out of done
	complete_held: assert property (@(posedge sd_clock) disable iff (!arst_n)
		complete && !ack_in && !idle_in |=> complete)
		else $error("complete fell before ack_in");

	pin_released_on_receive: assert property (@(posedge sd_clock) disable iff (!arst_n)
		enable_rx |-> !pad_enable)
		else $error("pad is driven while the receiver is enabled");

endmodule

bind dat_phys_controller dat_phys_properties i_properties (
	.sd_clock(sd_clock),
	.arst_n(arst_n),
	.read_enable(read_enable),
	.write_enable(write_enable),
	.ack_out(ack_out),
	.complete(complete),
	.ack_in(ack_in),
	.idle_in(idle_in),
	.enable_rx(enable_rx),
	.pad_enable(pad_enable)
);

// File: sim/dat_phys_tb.sv
`timescale 1ns/100ps

module dat_phys_tb
	import dat_phys_pkg::*;
();

	// worst case per block with status and token gaps
	localparam int block_cycles = 120;
	localparam int test_overhead = 40;
	localparam int total_blocks = 1 + 5 + 2 + 1 + 4 + 1;
	localparam int watchdog_cycles = total_blocks * block_cycles + 6 * test_overhead + 80 + 200;
	localparam int complete_limit = 300;

	logic sd_clock;
	logic arst_n;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	logic [63:0] timeout_reg;
	logic [block_width-1:0] blocks;
	logic write_read;
	logic multiple;
	logic status = 1'b0;
	logic [data_width-1:0] dat_from_fifo = '0;
	logic serial_ready;
	logic complete;
	logic ack_out;
	logic data_timeout;
	logic data_error;
	logic read_enable;
	logic write_enable;
	logic [data_width-1:0] data_to_fifo;
	wire dat_pin;

	// card side of the pin idles high
	logic card_drive = 1'b1;
	logic card_bit = 1'b1;

	logic [data_width-1:0] tx_words[$];
	logic [data_frame_width-1:0] exp_q[$];
	logic [data_frame_width-1:0] got_q[$];
	bit gaps_on = 1'b0;
	int re_count = 0;
	int we_count = 0;
	int compared = 0;
	int frame_errors = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	assign dat_pin = card_drive ? card_bit : 1'bz;

	dat_phys i_dat_phys (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.timeout_reg(timeout_reg),
		.blocks(blocks),
		.write_read(write_read),
		.multiple(multiple),
		.serial_ready(serial_ready),
		.complete(complete),
		.ack_out(ack_out),
		.data_timeout(data_timeout),
		.data_error(data_error),
		.read_enable(read_enable),
		.write_enable(write_enable),
		.data_to_fifo(data_to_fifo),
		.status(status),
		.dat_from_fifo(dat_from_fifo),
		.dat_pin(dat_pin)
	);

	// expected frame on the line for one word
	function automatic logic [data_frame_width-1:0] frame_word(input logic [31:0] word);
		return {1'b0, word, 16'hffff, 1'b1};
	endfunction

	initial begin
		sd_clock = 1'b0;
		forever #50 sd_clock = ~sd_clock;
	end

	// transmit FIFO, receive FIFO and strobe counters
	always @(posedge sd_clock) begin
		if (read_enable) begin
			re_count++;
			if (tx_words.size() > 0) begin
				dat_from_fifo <= tx_words[0];
				exp_q.push_back(frame_word(tx_words[0]));
				void'(tx_words.pop_front());
			end
		end
		if (write_enable) begin
			we_count++;
			got_q.push_back(frame_word(data_to_fifo));
		end
		status <= (tx_words.size() > 0) && (!gaps_on || ($urandom_range(3) != 0));
	end

	// pairs captured frames with expected frames in order
	always @(posedge sd_clock) begin
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			assert (got_q[0] === exp_q[0])
			else begin
				$display("error at %0t: frame %h, expected %h", $time, got_q[0], exp_q[0]);
				frame_errors++;
			end
			compared++;
			void'(got_q.pop_front());
			void'(exp_q.pop_front());
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge sd_clock);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic check(input bit ok, input string what);
		checks++;
		assert (ok)
		else begin
			$display("error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic start_transfer(input bit wr, input bit mult, input int nblk,
			input logic [63:0] tmo);
		@(posedge sd_clock);
		write_read <= wr;
		multiple <= mult;
		blocks <= nblk[block_width-1:0];
		timeout_reg <= tmo;
		strobe_in <= 1'b1;
		@(posedge sd_clock);
		strobe_in <= 1'b0;
	endtask

	task automatic wait_complete(output int cycles);
		cycles = 0;
		do begin
			@(posedge sd_clock);
			cycles++;
		end while (!complete && cycles < complete_limit);
		if (!complete) begin
			$display("the DUT gave no complete within %0d cycles", complete_limit);
			errors++;
		end
	endtask

	task automatic acknowledge();
		@(posedge sd_clock);
		ack_in <= 1'b1;
		@(posedge sd_clock);
		ack_in <= 1'b0;
		@(negedge sd_clock);
		check(ack_out && !complete, "ack_out missing or complete still high");
		@(negedge sd_clock);
		check(!ack_out && serial_ready, "ack_out too long or serial_ready not back");
	endtask

	// card receiving written blocks and answering each with a token
	task automatic card_write(input int n, input int reject_at);
		logic [data_frame_width-1:0] frame;
		logic [2:0] tok;
		logic [2:0] bad_tokens[3];
		int gap;
		bad_tokens = '{3'b000, 3'b001, 3'b011};
		for (int b = 0; b < n; b++) begin
			do @(posedge sd_clock); while (!read_enable);
			card_drive <= 1'b0;
			// start bit reaches the pin three cycles after the fetch
			repeat (2) @(posedge sd_clock);
			for (int i = 0; i < data_frame_width; i++) begin
				@(negedge sd_clock);
				frame[data_frame_width-1-i] = dat_pin;
			end
			got_q.push_back(frame);
			@(posedge sd_clock);
			card_drive <= 1'b1;
			card_bit <= 1'b1;
			gap = $urandom_range(6);
			repeat (gap) @(posedge sd_clock);
			tok = (b == reject_at) ? bad_tokens[$urandom_range(2)] : 3'b010;
			for (int i = 2; i >= 0; i--) begin
				@(posedge sd_clock);
				card_bit <= tok[i];
			end
			@(posedge sd_clock);
			card_bit <= 1'b1;
			if (b == reject_at) begin
				break;
			end
		end
	endtask

	// card playing back read blocks
	task automatic card_read(input int n);
		logic [data_frame_width-1:0] frame;
		int gap;
		for (int b = 0; b < n; b++) begin
			gap = $urandom_range(8);
			if (b == 0) begin
				repeat (gap + 4) @(posedge sd_clock);
			end else begin
				do @(posedge sd_clock); while (!write_enable);
				repeat (gap) @(posedge sd_clock);
			end
			frame = frame_word($urandom);
			exp_q.push_back(frame);
			for (int i = 0; i < data_frame_width; i++) begin
				@(posedge sd_clock);
				card_bit <= frame[data_frame_width-1-i];
			end
			@(posedge sd_clock);
			card_bit <= 1'b1;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		int errs;
		errs = errors + frame_errors - errs_before;
		tests++;
		$display("test %0d %s: %s", tests, name, (errs == 0) ? "ok" : "failed");
	endtask

	task automatic run_write(input string name, input int n, input bit mult,
			input int reject_at);
		int errs_before;
		int re_base;
		int cmp_base;
		int cycles;
		int expect_blocks;
		errs_before = errors + frame_errors;
		re_base = re_count;
		cmp_base = compared;
		expect_blocks = (reject_at >= 0) ? reject_at + 1 : n;
		for (int i = 0; i < n; i++) begin
			tx_words.push_back($urandom);
		end
		fork
			card_write(n, reject_at);
			begin
				start_transfer(1'b1, mult, n, 64'd1000);
				if (!gaps_on) begin
					@(negedge sd_clock);
					check(read_enable, "read_enable not high in the cycle after strobe_in");
				end
			end
		join
		wait_complete(cycles);
		check(data_error == (reject_at >= 0), "data_error does not match the token");
		check(!data_timeout, "data_timeout raised on a write");
		acknowledge();
		check(re_count - re_base == expect_blocks, "wrong number of read_enable pulses");
		check(compared - cmp_base == expect_blocks, "wrong number of frames on the pin");
		tx_words.delete();
		report_test(name, errs_before);
	endtask

	task automatic run_read(input string name, input int n, input bit mult);
		int errs_before;
		int we_base;
		int cmp_base;
		int cycles;
		int expect_blocks;
		errs_before = errors + frame_errors;
		we_base = we_count;
		cmp_base = compared;
		expect_blocks = mult ? n : 1;
		fork
			card_read(expect_blocks);
			start_transfer(1'b0, mult, n, 64'd1000);
		join
		wait_complete(cycles);
		check(!data_error && !data_timeout, "error flag raised on a read");
		acknowledge();
		check(we_count - we_base == expect_blocks, "wrong number of write_enable pulses");
		check(compared - cmp_base == expect_blocks, "wrong number of pushed words");
		report_test(name, errs_before);
	endtask

	task automatic run_timeout();
		int errs_before;
		int cycles;
		int t;
		errs_before = errors + frame_errors;
		t = $urandom_range(60, 5);
		start_transfer(1'b0, 1'b0, 1, 64'(t));
		wait_complete(cycles);
		// the wait starts in the cycle after strobe_in
		check(cycles - 1 >= t, "data_timeout before timeout_reg cycles");
		check(cycles - 1 <= t + 2, "data_timeout late");
		check(data_timeout && !data_error, "data_timeout not raised");
		acknowledge();
		report_test("timeout", errs_before);
	endtask

	task automatic run_abort();
		int errs_before;
		bit seen_complete;
		errs_before = errors + frame_errors;
		seen_complete = 1'b0;
		tx_words.push_back($urandom);
		start_transfer(1'b1, 1'b0, 1, 64'd1000);
		card_drive <= 1'b0;
		repeat (15) @(posedge sd_clock);
		idle_in <= 1'b1;
		@(posedge sd_clock);
		idle_in <= 1'b0;
		repeat (6) begin
			@(negedge sd_clock);
			if (complete) begin
				seen_complete = 1'b1;
			end
		end
		check(!seen_complete, "complete raised after idle_in");
		check(serial_ready, "serial_ready not back after idle_in");
		@(posedge sd_clock);
		card_drive <= 1'b1;
		card_bit <= 1'b1;
		exp_q.delete();
		tx_words.delete();
		report_test("abort", errs_before);
	endtask

	initial begin
		void'($urandom(32'h1d88_5eaf));
		arst_n = 1'b0;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		timeout_reg = '0;
		blocks = '0;
		write_read = 1'b0;
		multiple = 1'b0;
		repeat (5) @(posedge sd_clock);
		arst_n <= 1'b1;
		@(negedge sd_clock);
		check(serial_ready && !complete && !ack_out, "wrong host outputs after reset");
		check(!read_enable && !write_enable, "FIFO strobes high after reset");
		check(!data_timeout && !data_error, "error flags high after reset");

		run_write("single write", 1, 1'b0, -1);
		gaps_on = 1'b1;
		run_write("multiple write", 5, 1'b1, -1);
		run_write("rejected token", 3, 1'b1, 1);
		gaps_on = 1'b0;
		run_read("single read", 7, 1'b0);
		run_read("multiple read", 4, 1'b1);
		run_timeout();
		run_abort();

		errors += frame_errors;
		checks += compared;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
